/* Makefile */
VERILATOR ?= verilator
TOP       ?= fu_main_tb
FILELIST  ?= fu_main.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* fu_main.f */
rtl/fu_pkg.sv
rtl/fu_if.sv
rtl/fu_ctrl.sv
rtl/fu_alu.sv
rtl/fu_br.sv
rtl/fu_mult.sv
rtl/fu_main.sv
verification/fu_main_chk.sv
verification/fu_main_tb.sv

/* rtl/fu_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module fu_alu import fu_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  logic      start_i,
	input  logic      flush_i,
	fu_issue_if.unit  iss,
	fu_result_if.unit res
);

	word_t    result;
	logic     vld_q;
	word_t    value_q;
	prf_tag_t tag_q;
	rob_idx_t rob_q;

	always_comb begin
		case (iss.op)
			OP_ADD:   result = iss.opa + iss.opb;
			OP_SUB:   result = iss.opa - iss.opb;
			OP_AND:   result = iss.opa & iss.opb;
			OP_OR:    result = iss.opa | iss.opb;
			OP_XOR:   result = iss.opa ^ iss.opb;
			OP_SLL:   result = iss.opa << iss.opb[5:0];
			OP_SRL:   result = iss.opa >> iss.opb[5:0];
			OP_CMPEQ: result = word_t'(iss.opa == iss.opb);
			OP_CMPLT: result = word_t'($signed(iss.opa) < $signed(iss.opb));
			default:  result = '0;	// not an alu op
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i || flush_i)
			vld_q <= 1'b0;
		else if (start_i)
			vld_q <= 1'b1;	// may refill in the cycle the old one leaves
		else if (res.grant)
			vld_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			value_q <= result;
			tag_q   <= iss.dest_tag;
			rob_q   <= iss.rob_idx;
		end
	end

	assign res.vld     = vld_q;
	assign res.wr_en   = vld_q && (tag_q != ZERO_REG);
	assign res.tag     = tag_q;
	assign res.value   = value_q;
	assign res.rob_idx = rob_q;

endmodule

`default_nettype wire

/* rtl/fu_br.sv */
`timescale 1ns/100ps
`default_nettype none

module fu_br import fu_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  logic      start_i,
	input  logic      flush_i,
	fu_issue_if.unit  iss,
	fu_result_if.unit res,
	output logic      br_taken_o,
	output word_t     br_target_o
);

	logic     taken;
	logic     link;
	logic     vld_q;
	logic     taken_q;
	logic     link_q;
	word_t    target_q;
	word_t    npc_q;
	prf_tag_t tag_q;
	rob_idx_t rob_q;

	always_comb begin
		case (iss.op)
			OP_BEQ:  taken = (iss.opa == '0);
			OP_BNE:  taken = (iss.opa != '0);
			OP_BLT:  taken = iss.opa[XLEN-1];	// sign bit
			OP_JMP:  taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// only jumps link, and never to the zero register
	assign link = (iss.op == OP_JMP) && (iss.dest_tag != ZERO_REG);

	always_ff @(posedge clk) begin
		if (reset_i || flush_i)
			vld_q <= 1'b0;
		else if (start_i)
			vld_q <= 1'b1;
		else if (res.grant)
			vld_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			taken_q  <= taken;
			link_q   <= link;
			target_q <= (iss.op == OP_JMP) ? iss.opb : iss.npc + iss.opb;
			npc_q    <= iss.npc;
			tag_q    <= iss.dest_tag;
			rob_q    <= iss.rob_idx;
		end
	end

	assign res.vld     = vld_q;
	assign res.wr_en   = vld_q & link_q;
	assign res.tag     = tag_q;
	assign res.value   = npc_q;	// link value
	assign res.rob_idx = rob_q;
	assign br_taken_o  = vld_q & taken_q;
	assign br_target_o = target_q;

endmodule

`default_nettype wire

/* rtl/fu_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module fu_ctrl import fu_pkg::*; (
	input  logic        clk,
	input  logic        reset_i,
	input  logic        iss_vld_i,
	input  fu_sel_e     iss_sel_i,
	input  logic        recovery_i,
	output logic        iss_rdy_o,
	output logic        alu_start_o,
	output logic        br_start_o,
	output logic        mult_start_o,
	fu_result_if.arb    alu_res,
	fu_result_if.arb    br_res,
	fu_result_if.arb    mult_res,
	output logic        done_o,
	output logic        cdb_vld_o,
	output prf_tag_t    cdb_tag_o,
	output word_t       cdb_value_o,
	output rob_idx_t    rob_idx_o,
	output logic        br_done_o
);

	logic [MULT_STAGES-1:0] mult_sched_q;	// bit n set: product n+1 cycles old
	logic                   iss_fire;
	logic                   win_vld;
	logic                   win_wr;

	assign iss_rdy_o = ~((alu_res.vld & ~alu_res.grant) | (br_res.vld & ~br_res.grant));
	assign iss_fire  = iss_vld_i & iss_rdy_o & ~recovery_i;

	always_comb begin
		alu_start_o  = 1'b0;
		br_start_o   = 1'b0;
		mult_start_o = 1'b0;
		if (iss_fire) begin
			case (iss_sel_i)
				SEL_ALU:  alu_start_o  = 1'b1;
				SEL_BR:   br_start_o   = 1'b1;
				SEL_MULT: mult_start_o = 1'b1;
				default:  ;	// SEL_NONE retires nothing here
			endcase
		end
	end

	// multiplier slot is known ahead, fixed latency
	always_ff @(posedge clk) begin
		if (reset_i || recovery_i)
			mult_sched_q <= '0;
		else
			mult_sched_q <= {mult_sched_q[MULT_STAGES-2:0], mult_start_o};
	end

	assign mult_res.grant = mult_sched_q[MULT_STAGES-1];
	assign br_res.grant   = br_res.vld & ~mult_res.grant;
	assign alu_res.grant  = alu_res.vld & ~mult_res.grant & ~br_res.vld;

	always_comb begin
		win_vld     = 1'b0;
		win_wr      = 1'b0;
		cdb_tag_o   = ZERO_REG;
		cdb_value_o = '0;
		rob_idx_o   = '0;
		if (mult_res.grant && mult_res.vld) begin
			win_vld     = 1'b1;
			win_wr      = mult_res.wr_en;
			cdb_tag_o   = mult_res.tag;
			cdb_value_o = mult_res.value;
			rob_idx_o   = mult_res.rob_idx;
		end else if (br_res.grant) begin
			win_vld     = 1'b1;
			win_wr      = br_res.wr_en;
			cdb_tag_o   = br_res.tag;
			cdb_value_o = br_res.value;
			rob_idx_o   = br_res.rob_idx;
		end else if (alu_res.grant) begin
			win_vld     = 1'b1;
			win_wr      = alu_res.wr_en;
			cdb_tag_o   = alu_res.tag;
			cdb_value_o = alu_res.value;
			rob_idx_o   = alu_res.rob_idx;
		end
	end

	assign done_o    = win_vld & ~recovery_i;
	assign cdb_vld_o = win_wr & ~recovery_i;
	assign br_done_o = br_res.grant & ~recovery_i;

endmodule

`default_nettype wire

/* rtl/fu_if.sv */
`timescale 1ns/100ps
`default_nettype none

// issue bundle, shared by all units
interface fu_issue_if import fu_pkg::*; ();
	fu_op_e   op;
	word_t    opa;
	word_t    opb;
	prf_tag_t dest_tag;
	rob_idx_t rob_idx;
	word_t    npc;

	modport src  (output op, opa, opb, dest_tag, rob_idx, npc);
	modport unit (input  op, opa, opb, dest_tag, rob_idx, npc);
endinterface

// one per unit, result moves on vld && grant
interface fu_result_if import fu_pkg::*; ();
	logic     vld;
	logic     wr_en;
	prf_tag_t tag;
	word_t    value;
	rob_idx_t rob_idx;
	logic     grant;

	modport unit (output vld, wr_en, tag, value, rob_idx, input grant);
	modport arb  (input vld, wr_en, tag, value, rob_idx, output grant);
endinterface

`default_nettype wire

/* rtl/fu_main.sv */
`timescale 1ns/100ps
`default_nettype none

module fu_main import fu_pkg::*; (
	input  logic     clk,
	input  logic     reset_i,
	input  logic     iss_vld_i,
	input  fu_sel_e  iss_sel_i,
	input  fu_op_e   iss_op_i,
	input  word_t    iss_opa_i,
	input  word_t    iss_opb_i,
	input  word_t    iss_npc_i,
	input  prf_tag_t iss_dest_tag_i,
	input  rob_idx_t iss_rob_idx_i,
	input  logic     recovery_i,
	output logic     iss_rdy_o,
	output logic     done_o,
	output rob_idx_t rob_idx_o,
	output logic     cdb_vld_o,
	output prf_tag_t cdb_tag_o,
	output word_t    cdb_value_o,
	output logic     br_done_o,
	output logic     br_taken_o,
	output word_t    br_target_o
);

	logic alu_start;
	logic br_start;
	logic mult_start;

	fu_issue_if  iss_bus ();
	fu_result_if alu_bus ();
	fu_result_if br_bus ();
	fu_result_if mult_bus ();

	assign iss_bus.op       = iss_op_i;
	assign iss_bus.opa      = iss_opa_i;
	assign iss_bus.opb      = iss_opb_i;
	assign iss_bus.dest_tag = iss_dest_tag_i;
	assign iss_bus.rob_idx  = iss_rob_idx_i;
	assign iss_bus.npc      = iss_npc_i;

	fu_ctrl u_fu_ctrl (
		.clk(clk), .reset_i(reset_i), .iss_vld_i(iss_vld_i), .iss_sel_i(iss_sel_i),
		.recovery_i(recovery_i), .iss_rdy_o(iss_rdy_o), .alu_start_o(alu_start),
		.br_start_o(br_start), .mult_start_o(mult_start), .alu_res(alu_bus),
		.br_res(br_bus), .mult_res(mult_bus), .done_o(done_o), .cdb_vld_o(cdb_vld_o),
		.cdb_tag_o(cdb_tag_o), .cdb_value_o(cdb_value_o), .rob_idx_o(rob_idx_o),
		.br_done_o(br_done_o)
	);

	fu_alu u_fu_alu (.clk(clk), .reset_i(reset_i), .start_i(alu_start),
		.flush_i(recovery_i), .iss(iss_bus), .res(alu_bus));

	fu_br u_fu_br (.clk(clk), .reset_i(reset_i), .start_i(br_start),
		.flush_i(recovery_i), .iss(iss_bus), .res(br_bus),
		.br_taken_o(br_taken_o), .br_target_o(br_target_o));

	fu_mult u_fu_mult (.clk(clk), .reset_i(reset_i), .start_i(mult_start),
		.flush_i(recovery_i), .iss(iss_bus), .res(mult_bus));

endmodule

`default_nettype wire

/* rtl/fu_mult.sv */
`timescale 1ns/100ps
`default_nettype none

module fu_mult import fu_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  logic      start_i,
	input  logic      flush_i,
	fu_issue_if.unit  iss,
	fu_result_if.unit res
);

	logic [MULT_STAGES-1:0] vld_q;
	word_t    a_in [MULT_STAGES];
	word_t    b_in [MULT_STAGES];
	word_t    acc_in [MULT_STAGES];
	prf_tag_t tag_in [MULT_STAGES];
	rob_idx_t rob_in [MULT_STAGES];
	word_t    a_q [MULT_STAGES-1];	// last stage needs no operands
	word_t    b_q [MULT_STAGES-1];
	word_t    acc_q [MULT_STAGES];
	prf_tag_t tag_q [MULT_STAGES];
	rob_idx_t rob_q [MULT_STAGES];

	always_comb begin
		a_in[0]   = iss.opa;
		b_in[0]   = iss.opb;
		acc_in[0] = '0;
		tag_in[0] = iss.dest_tag;
		rob_in[0] = iss.rob_idx;
		for (int k = 1; k < MULT_STAGES; k++) begin
			a_in[k]   = a_q[k-1];
			b_in[k]   = b_q[k-1];
			acc_in[k] = acc_q[k-1];
			tag_in[k] = tag_q[k-1];
			rob_in[k] = rob_q[k-1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i || flush_i)
			vld_q <= '0;
		else
			vld_q <= {vld_q[MULT_STAGES-2:0], start_i};
	end

	// each stage adds opa times the next slice of opb, slices walk down
	always_ff @(posedge clk) begin
		for (int k = 0; k < MULT_STAGES; k++) begin
			acc_q[k] <= acc_in[k] + a_in[k] * word_t'(b_in[k][MULT_PART_W-1:0]);
			tag_q[k] <= tag_in[k];
			rob_q[k] <= rob_in[k];
		end
		for (int k = 0; k < MULT_STAGES - 1; k++) begin
			a_q[k] <= a_in[k] << MULT_PART_W;
			b_q[k] <= b_in[k] >> MULT_PART_W;
		end
	end

	assign res.vld     = vld_q[MULT_STAGES-1];	// always granted
	assign res.wr_en   = vld_q[MULT_STAGES-1] && (tag_q[MULT_STAGES-1] != ZERO_REG);
	assign res.tag     = tag_q[MULT_STAGES-1];
	assign res.value   = acc_q[MULT_STAGES-1];
	assign res.rob_idx = rob_q[MULT_STAGES-1];

endmodule

`default_nettype wire

/* rtl/fu_pkg.sv */
`default_nettype none

package fu_pkg;

	localparam int XLEN        = 64;
	localparam int PRF_IDX_W   = 6;
	localparam int ROB_IDX_W   = 6;	// includes wrap bit
	localparam int MULT_STAGES = 3;
	localparam int MULT_PART_W = (XLEN + MULT_STAGES - 1) / MULT_STAGES;	// opb bits per stage

	typedef logic [XLEN-1:0]      word_t;
	typedef logic [PRF_IDX_W-1:0] prf_tag_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;

	localparam prf_tag_t ZERO_REG = prf_tag_t'(31);	// no register write

	typedef enum logic [1:0] {
		SEL_NONE,
		SEL_ALU,
		SEL_BR,
		SEL_MULT
	} fu_sel_e;

	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLL,
		OP_SRL,
		OP_CMPEQ,
		OP_CMPLT,
		OP_MULQ,
		OP_BEQ,
		OP_BNE,
		OP_BLT,
		OP_JMP
	} fu_op_e;

endpackage

`default_nettype wire

/* verification/fu_main_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module fu_main_chk import fu_pkg::*; (
	input logic clk,
	input logic reset_i,
	input logic recovery_i,
	input logic iss_rdy_i,
	input logic alu_start_i,
	input logic br_start_i,
	input logic mult_start_i,
	input logic alu_grant_i,
	input logic br_grant_i,
	input logic mult_grant_i,
	input logic mult_vld_i,
	input logic done_i
);

	grant_onehot: assert property (@(posedge clk) disable iff (reset_i)
		$onehot0({alu_grant_i, br_grant_i, mult_grant_i}))
		else $error("more than one unit granted the completion bus");

	start_needs_rdy: assert property (@(posedge clk) disable iff (reset_i)
		!iss_rdy_i |-> !(alu_start_i || br_start_i || mult_start_i))
		else $error("unit started while iss_rdy_o low");

	done_masked: assert property (@(posedge clk) disable iff (reset_i)
		recovery_i |-> !done_i)
		else $error("done_o high during recovery");

	// fixed latency, every product out of the pipeline traces back to its start
	mult_latency: assert property (@(posedge clk) disable iff (reset_i)
		mult_vld_i |-> $past(mult_start_i, MULT_STAGES))
		else $error("mult completion not MULT_STAGES cycles after start");

endmodule

bind fu_ctrl fu_main_chk u_fu_main_chk (
	.clk(clk),
	.reset_i(reset_i),
	.recovery_i(recovery_i),
	.iss_rdy_i(iss_rdy_o),
	.alu_start_i(alu_start_o),
	.br_start_i(br_start_o),
	.mult_start_i(mult_start_o),
	.alu_grant_i(alu_res.grant),
	.br_grant_i(br_res.grant),
	.mult_grant_i(mult_res.grant),
	.mult_vld_i(mult_res.vld),
	.done_i(done_o)
);

`default_nettype wire

/* verification/fu_main_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module fu_main_tb import fu_pkg::*; ();

	typedef struct packed {
		logic     wr;
		prf_tag_t tag;
		word_t    value;
		logic     br;
		logic     taken;
		word_t    target;
	} exp_t;

	localparam int ROB_N         = 1 << ROB_IDX_W;
	localparam int ISS_TIMEOUT   = 50;
	localparam int DRAIN_TIMEOUT = 200;

	logic     clk;
	logic     reset_i;
	logic     iss_vld_i;
	fu_sel_e  iss_sel_i;
	fu_op_e   iss_op_i;
	word_t    iss_opa_i;
	word_t    iss_opb_i;
	word_t    iss_npc_i;
	prf_tag_t iss_dest_tag_i;
	rob_idx_t iss_rob_idx_i;
	logic     recovery_i;
	logic     iss_rdy_o;
	logic     done_o;
	rob_idx_t rob_idx_o;
	logic     cdb_vld_o;
	prf_tag_t cdb_tag_o;
	word_t    cdb_value_o;
	logic     br_done_o;
	logic     br_taken_o;
	word_t    br_target_o;

	// scoreboard by rob index
	exp_t     sb [ROB_N];
	logic     pend [ROB_N];
	logic     flushed [ROB_N];
	logic     is_mult [ROB_N];
	int       acc_cyc [ROB_N];

	integer   seed = 32'h950527e5;
	int       cyc = 0;
	int       errors = 0;
	int       checks = 0;
	int       tests = 0;
	logic     timed_out = 1'b0;
	logic     saw_stall = 1'b0;
	rob_idx_t next_rob = '0;

	fu_op_e alu_ops [9] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL,
		OP_CMPEQ, OP_CMPLT};
	fu_op_e br_ops [4] = '{OP_BEQ, OP_BNE, OP_BLT, OP_JMP};

	fu_main u_fu_main (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	function automatic exp_t fu_model(input fu_sel_e sel, input fu_op_e op, input word_t a,
			input word_t b, input word_t npc, input prf_tag_t tag);
		exp_t e;
		e     = '0;
		e.tag = tag;
		case (sel)
			SEL_ALU: begin
				e.wr = (tag != ZERO_REG);
				case (op)
					OP_ADD:   e.value = a + b;
					OP_SUB:   e.value = a - b;
					OP_AND:   e.value = a & b;
					OP_OR:    e.value = a | b;
					OP_XOR:   e.value = a ^ b;
					OP_SLL:   e.value = a << b[5:0];
					OP_SRL:   e.value = a >> b[5:0];
					OP_CMPEQ: e.value = (a == b) ? 64'd1 : 64'd0;
					OP_CMPLT: e.value = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
					default:  e.value = '0;
				endcase
			end
			SEL_MULT: begin
				e.wr    = (tag != ZERO_REG);
				e.value = a * b;	// low 64 bits
			end
			SEL_BR: begin
				e.br = 1'b1;
				case (op)
					OP_BEQ:  e.taken = (a == '0);
					OP_BNE:  e.taken = (a != '0);
					OP_BLT:  e.taken = ($signed(a) < 64'sd0);
					OP_JMP:  e.taken = 1'b1;
					default: e.taken = 1'b0;
				endcase
				e.target = (op == OP_JMP) ? b : npc + b;
				e.wr     = (op == OP_JMP) && (tag != ZERO_REG);
				e.value  = npc;	// link
			end
			default: ;
		endcase
		return e;
	endfunction

	function automatic word_t rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic prf_tag_t rand_tag();
		prf_tag_t t;
		t = prf_tag_t'($random(seed));
		if (($random(seed) & 7) == 0)
			t = ZERO_REG;	// some ops without a write
		return t;
	endfunction

	function automatic int pend_count();
		int n;
		n = 0;
		for (int i = 0; i < ROB_N; i++)
			if (pend[i])
				n++;
		return n;
	endfunction

	task automatic check_cdb(input rob_idx_t rob, input logic vld, input prf_tag_t tag,
			input word_t value);
		exp_t e;
		e = sb[rob];
		if (vld !== e.wr) begin
			errors++;
			$display("MISMATCH cdb_vld_o rob %h: got %h exp %h", rob, vld, e.wr);
		end else if (e.wr) begin
			if (tag !== e.tag) begin
				errors++;
				$display("MISMATCH cdb_tag_o rob %h: got %h exp %h", rob, tag, e.tag);
			end
			if (value !== e.value) begin
				errors++;
				$display("MISMATCH cdb_value_o rob %h: got %h exp %h", rob, value, e.value);
			end
		end
	endtask

	task automatic check_branch(input rob_idx_t rob, input logic br_done, input logic taken,
			input word_t target);
		exp_t e;
		e = sb[rob];
		if (br_done !== e.br) begin
			errors++;
			$display("MISMATCH br_done_o rob %h: got %h exp %h", rob, br_done, e.br);
		end else if (e.br) begin
			if (taken !== e.taken) begin
				errors++;
				$display("MISMATCH br_taken_o rob %h: got %h exp %h", rob, taken, e.taken);
			end
			if (target !== e.target) begin
				errors++;
				$display("MISMATCH br_target_o rob %h: got %h exp %h", rob, target, e.target);
			end
		end
	endtask

	// compare at negedge, outputs settled
	always @(negedge clk) begin
		if (!reset_i) begin
			if (!iss_rdy_o)
				saw_stall = 1'b1;
			if (recovery_i) begin
				if (done_o || cdb_vld_o) begin
					errors++;
					$display("done_o or cdb_vld_o high during recovery");
				end
				for (int i = 0; i < ROB_N; i++) begin
					if (pend[i]) begin
						pend[i]    = 1'b0;
						flushed[i] = 1'b1;
					end
				end
			end else if (done_o) begin
				if (!pend[rob_idx_o]) begin
					errors++;
					if (flushed[rob_idx_o])
						$display("flushed rob %h completed", rob_idx_o);
					else
						$display("rob %h completed but was not pending", rob_idx_o);
				end else begin
					check_cdb(rob_idx_o, cdb_vld_o, cdb_tag_o, cdb_value_o);
					check_branch(rob_idx_o, br_done_o, br_taken_o, br_target_o);
					if (is_mult[rob_idx_o] && cyc - acc_cyc[rob_idx_o] != MULT_STAGES) begin
						errors++;
						$display("mult rob %h took %0d cycles instead of %0d", rob_idx_o,
							cyc - acc_cyc[rob_idx_o], MULT_STAGES);
					end
					pend[rob_idx_o] = 1'b0;
					checks++;
				end
			end else if (cdb_vld_o || br_done_o) begin
				errors++;
				$display("cdb_vld_o or br_done_o high without done_o");
			end
		end
	end

	task automatic issue_op(input fu_sel_e sel, input fu_op_e op, input word_t a,
			input word_t b, input word_t npc, input prf_tag_t tag);
		rob_idx_t rob;
		int       wait_cnt;
		rob      = next_rob;
		next_rob = next_rob + rob_idx_t'(1);
		wait_cnt = 0;
		@(posedge clk);
		iss_vld_i      <= 1'b1;
		iss_sel_i      <= sel;
		iss_op_i       <= op;
		iss_opa_i      <= a;
		iss_opb_i      <= b;
		iss_npc_i      <= npc;
		iss_dest_tag_i <= tag;
		iss_rob_idx_i  <= rob;
		@(negedge clk);
		while (!iss_rdy_o && !timed_out) begin
			if (wait_cnt == ISS_TIMEOUT) begin
				$display("timeout: iss_rdy_o stayed low for %0d cycles", ISS_TIMEOUT);
				timed_out = 1'b1;
			end else begin
				wait_cnt++;
				@(negedge clk);
			end
		end
		if (!timed_out) begin	// accepted on the coming edge
			sb[rob]      = fu_model(sel, op, a, b, npc, tag);
			is_mult[rob] = (sel == SEL_MULT);
			acc_cyc[rob] = cyc;
			flushed[rob] = 1'b0;
			pend[rob]    = 1'b1;
		end
	endtask

	task automatic issue_random(input fu_sel_e sel);
		fu_op_e   op;
		word_t    a;
		word_t    b;
		word_t    npc;
		prf_tag_t tag;
		int       k;
		k = $unsigned($random(seed)) % 9;
		case (sel)
			SEL_ALU: op = alu_ops[k];
			SEL_BR:  op = br_ops[k % 4];
			default: op = OP_MULQ;
		endcase
		a   = (($random(seed) & 3) == 0) ? '0 : rand_word();	// zero for beq/bne
		b   = rand_word();
		npc = rand_word();
		tag = rand_tag();
		issue_op(sel, op, a, b, npc, tag);
	endtask

	task automatic go_idle();
		@(posedge clk);
		iss_vld_i <= 1'b0;
	endtask

	task automatic recover();
		@(posedge clk);
		iss_vld_i  <= 1'b0;
		recovery_i <= 1'b1;
		@(posedge clk);
		recovery_i <= 1'b0;
	endtask

	task automatic drain();
		int wait_cnt;
		wait_cnt = 0;
		while (pend_count() != 0 && !timed_out) begin
			if (wait_cnt == DRAIN_TIMEOUT) begin
				$display("timeout: %0d ops never completed", pend_count());
				timed_out = 1'b1;
			end else begin
				wait_cnt++;
				@(negedge clk);
			end
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		go_idle();
		drain();
		repeat (MULT_STAGES + 2) @(posedge clk);	// catch stray completions
		tests++;
		$display("test %-10s %s", name, (errors == err_before && !timed_out) ? "ok" : "FAILED");
	endtask

	initial begin
		int err0;
		int k;
		reset_i        = 1'b1;
		iss_vld_i      = 1'b0;
		iss_sel_i      = SEL_NONE;
		iss_op_i       = OP_ADD;
		iss_opa_i      = '0;
		iss_opb_i      = '0;
		iss_npc_i      = '0;
		iss_dest_tag_i = ZERO_REG;
		iss_rob_idx_i  = '0;
		recovery_i     = 1'b0;
		for (int i = 0; i < ROB_N; i++) begin
			pend[i]    = 1'b0;
			flushed[i] = 1'b0;
		end
		repeat (10) @(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		if (!iss_rdy_o || done_o || cdb_vld_o || br_done_o) begin
			errors++;
			$display("outputs not idle after reset");
		end

		err0 = errors;
		for (int i = 0; i < 24; i++)
			issue_random(SEL_ALU);
		end_test("alu", err0);

		err0 = errors;
		for (int i = 0; i < 6; i++)
			issue_random(SEL_MULT);	// back to back, three in flight
		end_test("mult", err0);

		err0 = errors;
		for (int i = 0; i < 16; i++)
			issue_random(SEL_BR);
		end_test("branch", err0);

		err0      = errors;
		saw_stall = 1'b0;
		for (int i = 0; i < 4; i++) begin
			repeat (3) issue_random(SEL_MULT);
			issue_random(SEL_ALU);
			issue_random(SEL_BR);
		end
		if (!saw_stall) begin
			errors++;
			$display("iss_rdy_o never dropped during contention");
		end
		end_test("contention", err0);

		err0 = errors;
		issue_random(SEL_ALU);
		issue_random(SEL_BR);
		repeat (3) issue_random(SEL_MULT);
		issue_random(SEL_ALU);	// held behind a product when the flush hits
		recover();
		k = 0;
		for (int i = 0; i < ROB_N; i++)
			if (flushed[i])
				k++;
		if (k == 0) begin
			errors++;
			$display("recovery flushed no op in flight");
		end
		for (int i = 0; i < 10; i++) begin
			k = $unsigned($random(seed)) % 3;
			issue_random(k == 0 ? SEL_ALU : (k == 1 ? SEL_BR : SEL_MULT));
		end
		end_test("recovery", err0);

		$display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
		if (errors == 0 && !timed_out)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
